// ==== include/idli_macros.svh ====
`ifndef IDLI_MACROS_SVH
`define IDLI_MACROS_SVH

// Width of a full operand in bits.
// Every register holds one operand of this size.
`define IDLI_DATA_W 16

// Width of one slice in bits.
// An operand is processed one slice per cycle, so the operand width divided
// by the slice width gives the number of cycles in an execution slot.
`define IDLI_SLICE_W 4

// Number of architectural registers.
// Register 0 always reads as zero.
`define IDLI_NUM_REGS 16

// Width of the conditional execution mask.
`define IDLI_COND_W 8

// Number of single bit IO pins in each direction.
`define IDLI_NUM_PINS 4

`endif

// ==== logic/idli_pkg.sv ====
`default_nettype none

`include "idli_macros.svh"

package idli_pkg;

  // Basic data types.
  typedef logic [`IDLI_SLICE_W-1:0]                          slice_t;
  typedef logic [`IDLI_DATA_W-1:0]                           data_t;
  typedef logic [$clog2(`IDLI_NUM_REGS)-1:0]                 reg_t;
  typedef logic [$clog2(`IDLI_DATA_W/`IDLI_SLICE_W)-1:0]     ctr_t;
  typedef logic [`IDLI_COND_W-1:0]                           cond_t;
  typedef logic [`IDLI_NUM_PINS-1:0]                         pins_t;

  // Opcodes as held in bits 15 to 12 of an encoding.
  // The values are fixed so that encodings can be written by hand.
  typedef enum logic [3:0] {
    OP_ADD     = 4'h0,
    OP_SUB     = 4'h1,
    OP_AND     = 4'h2,
    OP_OR      = 4'h3,
    OP_XOR     = 4'h4,
    OP_LDI     = 4'h5,
    OP_EQ      = 4'h6,
    OP_NE      = 4'h7,
    OP_LT      = 4'h8,
    OP_LTU     = 4'h9,
    OP_GE      = 4'ha,
    OP_GEU     = 4'hb,
    OP_COND    = 4'hc,
    OP_PIN_IN  = 4'hd,
    OP_PIN_OUT = 4'he,
    OP_NOP     = 4'hf
  } op_t;

  // Decoded instruction fields.
  // The sub flag also sets the carry in of the first slice.
  typedef struct packed {
    op_t              op;
    reg_t             dst;
    reg_t             lhs;
    reg_t             rhs;
    logic [7:0]       imm;
    logic             vld;
    logic             wr_reg;
    logic             wr_pred;
    logic             sub;
  } dec_t;

  // ALU flags, only complete on the final slice.
  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

  // One slice of register write back.
  typedef struct packed {
    logic   en;
    reg_t   dst;
    slice_t slice;
  } wb_t;

endpackage

`default_nettype wire

// ==== logic/idli_decode.sv ====
`default_nettype none

// Instruction decoder.
// The encoding is captured at the end of the sampling slot and held for the
// four cycles in which the instruction executes.
module idli_decode import idli_pkg::*; (
  // Clock and reset.
  input  var logic  i_de_gck,
  input  var logic  i_de_rst_n,

  // Slot position and the encoding presented for sampling.
  input  var ctr_t  i_de_ctr,
  input  var data_t i_de_enc,
  input  var logic  i_de_enc_vld,

  // Decoded fields of the held instruction.
  output var dec_t  o_de_dec
);

  // Captured encoding and its valid bit.
  data_t enc_q;
  logic  vld_q;

  // Opcode field of the captured encoding.
  op_t   op;

  // The valid bit says whether the held encoding is an instruction at all.
  always_ff @(posedge i_de_gck, negedge i_de_rst_n) begin
    if (!i_de_rst_n) begin
      vld_q <= 1'b0;
    end else if (&i_de_ctr) begin
      vld_q <= i_de_enc_vld;
    end
  end

  // The encoding stays put for the whole execution slot.
  always_ff @(posedge i_de_gck) begin
    if (&i_de_ctr) begin
      enc_q <= i_de_enc;
    end
  end

  always_comb op = op_t'(enc_q[15:12]);

  // Split the encoding into fields and derive the control flags.
  // Register fields are passed through even for operations that ignore them.
  always_comb begin
    o_de_dec         = '0;
    o_de_dec.op      = op;
    o_de_dec.dst     = enc_q[11:8];
    o_de_dec.lhs     = enc_q[7:4];
    o_de_dec.rhs     = enc_q[3:0];
    o_de_dec.imm     = enc_q[7:0];
    o_de_dec.vld     = vld_q;

    case (op)
      OP_ADD, OP_AND, OP_OR, OP_XOR, OP_LDI, OP_PIN_IN: begin
        o_de_dec.wr_reg = 1'b1;
      end
      OP_SUB: begin
        o_de_dec.wr_reg = 1'b1;
        o_de_dec.sub    = 1'b1;
      end
      OP_EQ, OP_NE, OP_LT, OP_LTU, OP_GE, OP_GEU: begin
        // Compares subtract and only keep the flags.
        o_de_dec.wr_pred = 1'b1;
        o_de_dec.sub     = 1'b1;
      end
      default: begin
        // COND, PIN_OUT and NOP write neither a register nor P.
        o_de_dec.wr_reg  = 1'b0;
      end
    endcase
  end

  // A valid encoding must be fully known when it is captured.
  a_de_enc_known: assert property (@(posedge i_de_gck) disable iff (!i_de_rst_n)
    &i_de_ctr && i_de_enc_vld |-> !$isunknown(i_de_enc));

endmodule

`default_nettype wire

// ==== logic/idli_ex_ctl.sv ====
`default_nettype none

`include "idli_macros.svh"

// Execute control.
// Runs the slot counter, holds P and the condition mask, decides whether the
// held instruction runs and builds the register write back.
module idli_ex_ctl import idli_pkg::*; (
  // Clock and reset.
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  // Decoded instruction and datapath results.
  input  var dec_t   i_ctl_dec,
  input  var flags_t i_ctl_flags,
  input  var slice_t i_ctl_alu_slice,
  input  var slice_t i_ctl_pin_slice,

  // Slot position and status.
  output var ctr_t   o_ctl_ctr,
  output var logic   o_ctl_slot,
  output var logic   o_ctl_run,

  // Register write back and predicate.
  output var wb_t    o_ctl_wb,
  output var logic   o_ctl_pred
);

  // Slot counter.
  ctr_t  ctr_q;
  logic  last;

  // Conditional execution mask and predicate.
  cond_t mask_q;
  logic  pred_q;
  logic  pred_d;
  logic  skip;

  // The counter free runs from reset and wraps every four cycles.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;
    end
  end

  // Final cycle of the slot, where state updates and the next encoding is taken.
  always_comb last = &ctr_q;

  // The mask only takes effect while any bit above the LSB is set.
  // Bit 0 then says whether to run when P is true or when P is false.
  always_comb begin
    if (~|mask_q[`IDLI_COND_W-1:1]) begin
      skip = 1'b0;
    end else begin
      skip = mask_q[0] ? !pred_q : pred_q;
    end
  end

  always_comb o_ctl_run = i_ctl_dec.vld && !skip;

  // Every valid instruction consumes one mask bit, skipped or not.
  // A COND that runs replaces the mask with its immediate.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      mask_q <= '0;
    end else if (last && i_ctl_dec.vld) begin
      if (o_ctl_run && i_ctl_dec.op == OP_COND) begin
        mask_q <= i_ctl_dec.imm;
      end else begin
        mask_q <= mask_q >> 1;
      end
    end
  end

  // Compare result from the flags of the final slice.
  // NE is the only compare left for the default arm.
  always_comb begin
    case (i_ctl_dec.op)
      OP_EQ:   pred_d = i_ctl_flags.z;
      OP_LT:   pred_d = i_ctl_flags.n != i_ctl_flags.v;
      OP_GE:   pred_d = i_ctl_flags.n == i_ctl_flags.v;
      OP_LTU:  pred_d = !i_ctl_flags.c;
      OP_GEU:  pred_d = i_ctl_flags.c;
      default: pred_d = !i_ctl_flags.z;
    endcase
  end

  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
    end else if (last && o_ctl_run && i_ctl_dec.wr_pred) begin
      pred_q <= pred_d;
    end
  end

  // Write back is active in all four cycles of a running instruction.
  always_comb begin
    o_ctl_wb.en    = o_ctl_run && i_ctl_dec.wr_reg;
    o_ctl_wb.dst   = i_ctl_dec.dst;
    o_ctl_wb.slice = i_ctl_dec.op == OP_PIN_IN ? i_ctl_pin_slice : i_ctl_alu_slice;
  end

  always_comb o_ctl_ctr  = ctr_q;
  always_comb o_ctl_slot = last;
  always_comb o_ctl_pred = pred_q;

  // A register write carries known data, so its source registers were written before.
  a_ctl_wb_known: assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    o_ctl_wb.en |-> !$isunknown(o_ctl_wb.slice));

endmodule

`default_nettype wire

// ==== logic/idli_rf.sv ====
`default_nettype none

`include "idli_macros.svh"

// Slice serial register file.
// Both read ports and the write port address the slice picked by the counter.
module idli_rf import idli_pkg::*; (
  input  var logic   i_rf_gck,

  // Slice position within the slot.
  input  var ctr_t   i_rf_ctr,

  // Read addresses.
  input  var reg_t   i_rf_lhs,
  input  var reg_t   i_rf_rhs,

  // Write back slice.
  input  var wb_t    i_rf_wb,

  // Read data for the current slice.
  output var slice_t o_rf_lhs_slice,
  output var slice_t o_rf_rhs_slice
);

  // Register storage, one full operand per register.
  data_t regs_q [`IDLI_NUM_REGS];

  // Register 0 is hard wired to zero so writes to it are dropped.
  logic  wr_en;

  always_comb wr_en   = i_rf_wb.en && i_rf_wb.dst != '0;

  always_ff @(posedge i_rf_gck) begin
    if (wr_en) begin
      regs_q[i_rf_wb.dst][i_rf_ctr*`IDLI_SLICE_W +: `IDLI_SLICE_W] <= i_rf_wb.slice;
    end
  end

  // Reads of register 0 return zero whatever the array holds.
  always_comb begin
    if (i_rf_lhs == '0) begin
      o_rf_lhs_slice = '0;
    end else begin
      o_rf_lhs_slice = regs_q[i_rf_lhs][i_rf_ctr*`IDLI_SLICE_W +: `IDLI_SLICE_W];
    end
  end

  always_comb begin
    if (i_rf_rhs == '0) begin
      o_rf_rhs_slice = '0;
    end else begin
      o_rf_rhs_slice = regs_q[i_rf_rhs][i_rf_ctr*`IDLI_SLICE_W +: `IDLI_SLICE_W];
    end
  end

  // A register is written whole, so a write continues into the next slice of
  // the same register until the last slice of the slot.
  a_rf_whole_write: assert property (@(posedge i_rf_gck)
    wr_en && !(&i_rf_ctr) |=> wr_en && i_rf_wb.dst == $past(i_rf_wb.dst));

endmodule

`default_nettype wire

// ==== logic/idli_alu.sv ====
`default_nettype none

`include "idli_macros.svh"

// Slice serial ALU.
// The carry is saved between slices so four cycles form one full width add.
module idli_alu import idli_pkg::*; (
  input  var logic   i_alu_gck,

  // Slice position and decoded instruction.
  input  var ctr_t   i_alu_ctr,
  input  var dec_t   i_alu_dec,

  // Operand slices from the register file.
  input  var slice_t i_alu_lhs,
  input  var slice_t i_alu_rhs,

  // Result slice and flags.
  output var slice_t o_alu_out,
  output var flags_t o_alu_flags
);

  // Adder operands and result, including the carry out as the top bit.
  slice_t                 rhs_eff;
  logic                   cin;
  logic [`IDLI_SLICE_W:0] add_full;
  slice_t                 sum;

  // Carry and zero state carried from one slice to the next.
  logic   carry_q;
  logic   zero_q;
  logic   zero;

  // Zero extended immediate and its slice for this cycle.
  data_t  imm_ext;
  slice_t imm_slice;

  // Subtraction is lhs plus the inverse of rhs plus one.
  always_comb rhs_eff = i_alu_dec.sub ? ~i_alu_rhs : i_alu_rhs;

  // The first slice takes its carry from the opcode.
  always_comb cin = ~|i_alu_ctr ? i_alu_dec.sub : carry_q;

  always_comb add_full = {1'b0, i_alu_lhs} + {1'b0, rhs_eff}
                       + {{`IDLI_SLICE_W{1'b0}}, cin};
  always_comb sum      = add_full[`IDLI_SLICE_W-1:0];

  always_comb imm_ext   = data_t'(i_alu_dec.imm);
  always_comb imm_slice = imm_ext[i_alu_ctr*`IDLI_SLICE_W +: `IDLI_SLICE_W];

  // Logic operations bypass the adder, everything else uses the sum.
  always_comb begin
    case (i_alu_dec.op)
      OP_AND:  o_alu_out = i_alu_lhs & i_alu_rhs;
      OP_OR:   o_alu_out = i_alu_lhs | i_alu_rhs;
      OP_XOR:  o_alu_out = i_alu_lhs ^ i_alu_rhs;
      OP_LDI:  o_alu_out = imm_slice;
      default: o_alu_out = sum;
    endcase
  end

  // The result is zero only if every slice so far was zero.
  always_comb zero = ~|o_alu_out && (~|i_alu_ctr || zero_q);

  always_ff @(posedge i_alu_gck) begin
    carry_q <= add_full[`IDLI_SLICE_W];
    zero_q  <= zero;
  end

  // N, C and V are only meaningful on the final slice.
  always_comb begin
    o_alu_flags.z = zero;
    o_alu_flags.n = sum[`IDLI_SLICE_W-1];
    o_alu_flags.c = add_full[`IDLI_SLICE_W];
    o_alu_flags.v = (i_alu_lhs[`IDLI_SLICE_W-1] == rhs_eff[`IDLI_SLICE_W-1])
                 && (sum[`IDLI_SLICE_W-1] != i_alu_lhs[`IDLI_SLICE_W-1]);
  end

endmodule

`default_nettype wire

// ==== logic/idli_pins.sv ====
`default_nettype none

`include "idli_macros.svh"

// Single bit IO pins.
module idli_pins import idli_pkg::*; (
  // Clock and reset.
  input  var logic   i_pin_gck,
  input  var logic   i_pin_rst_n,

  // Slot position, held instruction and whether it runs.
  input  var ctr_t   i_pin_ctr,
  input  var dec_t   i_pin_dec,
  input  var logic   i_pin_run,

  // Source register slice for PIN_OUT.
  input  var slice_t i_pin_lhs,

  // Pin read data and the pins themselves.
  input  var pins_t  i_pin_io,
  output var slice_t o_pin_slice,
  output var pins_t  o_pin_io
);

  localparam int PIN_IDX_W = $clog2(`IDLI_NUM_PINS);

  // Pin index taken from the low bits of the rhs field.
  logic [PIN_IDX_W-1:0] pin_idx;

  // Sampled inputs and driven outputs.
  pins_t in_q;
  pins_t out_q;

  always_comb pin_idx = i_pin_dec.rhs[PIN_IDX_W-1:0];

  // Inputs are sampled every cycle.
  always_ff @(posedge i_pin_gck) begin
    in_q <= i_pin_io;
  end

  // The pin value lands in bit 0 of the lowest slice, the upper slices are zero.
  always_comb o_pin_slice = ~|i_pin_ctr ? slice_t'(in_q[pin_idx]) : '0;

  // On the first slice the lhs slice holds register bit 0.
  always_ff @(posedge i_pin_gck, negedge i_pin_rst_n) begin
    if (!i_pin_rst_n) begin
      out_q <= '0;
    end else if (i_pin_run && i_pin_dec.op == OP_PIN_OUT && ~|i_pin_ctr) begin
      out_q[pin_idx] <= i_pin_lhs[0];
    end
  end

  always_comb o_pin_io = out_q;

endmodule

`default_nettype wire

// ==== logic/idli_ex.sv ====
`default_nettype none

// Nibble serial execute stage.
module idli_ex import idli_pkg::*; (
  // Clock and reset.
  input  var logic  i_ex_gck,
  input  var logic  i_ex_rst_n,

  // Encoding sampled in the last cycle of each slot.
  input  var data_t i_ex_enc,
  input  var logic  i_ex_enc_vld,
  output var logic  o_ex_slot,

  // Register write back and predicate, visible for checking.
  output var wb_t   o_ex_wb,
  output var logic  o_ex_pred,

  // IO pins.
  input  var pins_t i_ex_io_pins,
  output var pins_t o_ex_io_pins
);

  // Slot position and held instruction.
  ctr_t   ctr;
  dec_t   dec;
  logic   run;

  // Datapath slices and flags.
  slice_t lhs_slice;
  slice_t rhs_slice;
  slice_t alu_slice;
  slice_t pin_slice;
  flags_t flags;

  // Register write back, also driven out of the stage.
  wb_t    rf_wb;

  idli_ex_ctl ctl_u (
    .i_ex_gck        (i_ex_gck),
    .i_ex_rst_n      (i_ex_rst_n),
    .i_ctl_dec       (dec),
    .i_ctl_flags     (flags),
    .i_ctl_alu_slice (alu_slice),
    .i_ctl_pin_slice (pin_slice),
    .o_ctl_ctr       (ctr),
    .o_ctl_slot      (o_ex_slot),
    .o_ctl_run       (run),
    .o_ctl_wb        (rf_wb),
    .o_ctl_pred      (o_ex_pred)
  );

  idli_decode decode_u (
    .i_de_gck     (i_ex_gck),
    .i_de_rst_n   (i_ex_rst_n),
    .i_de_ctr     (ctr),
    .i_de_enc     (i_ex_enc),
    .i_de_enc_vld (i_ex_enc_vld),
    .o_de_dec     (dec)
  );

  idli_rf rf_u (
    .i_rf_gck       (i_ex_gck),
    .i_rf_ctr       (ctr),
    .i_rf_lhs       (dec.lhs),
    .i_rf_rhs       (dec.rhs),
    .i_rf_wb        (rf_wb),
    .o_rf_lhs_slice (lhs_slice),
    .o_rf_rhs_slice (rhs_slice)
  );

  idli_alu alu_u (
    .i_alu_gck   (i_ex_gck),
    .i_alu_ctr   (ctr),
    .i_alu_dec   (dec),
    .i_alu_lhs   (lhs_slice),
    .i_alu_rhs   (rhs_slice),
    .o_alu_out   (alu_slice),
    .o_alu_flags (flags)
  );

  idli_pins pins_u (
    .i_pin_gck   (i_ex_gck),
    .i_pin_rst_n (i_ex_rst_n),
    .i_pin_ctr   (ctr),
    .i_pin_dec   (dec),
    .i_pin_run   (run),
    .i_pin_lhs   (lhs_slice),
    .i_pin_io    (i_ex_io_pins),
    .o_pin_slice (pin_slice),
    .o_pin_io    (o_ex_io_pins)
  );

  assign o_ex_wb = rf_wb;

endmodule

`default_nettype wire

// ==== test/idli_ex_tb.sv ====
`default_nettype none

`include "idli_macros.svh"

// Testbench for the nibble serial execute stage.
// A vector is presented in the last cycle of one slot and executes in the
// next slot. Its write back is gathered there, and its effect on P and the
// output pins is checked at the start of the slot after that.
module idli_ex_tb import idli_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_VECS = 64;

  // DUT connections.
  logic  clk;
  logic  rst_n;
  data_t enc;
  logic  enc_vld;
  pins_t pins_in;
  logic  slot;
  wb_t   wb;
  logic  pred;
  pins_t pins_out;

  // Each vector is {encoding, input pins, write flag, result, P, output pins}.
  // The flag and P sit in the low bit of a hex digit of their own.
  logic [47:0] vecs [MAX_VECS];
  int          num_vecs;
  bit          loaded = 1'b0;

  int errors;
  int checks;

  // Write back seen in the four cycles of one instruction.
  data_t      wb_data;
  logic [3:0] wb_en;
  reg_t       wb_dst [4];

  idli_ex uut (
    .i_ex_gck     (clk),
    .i_ex_rst_n   (rst_n),
    .i_ex_enc     (enc),
    .i_ex_enc_vld (enc_vld),
    .o_ex_slot    (slot),
    .o_ex_wb      (wb),
    .o_ex_pred    (pred),
    .i_ex_io_pins (pins_in),
    .o_ex_io_pins (pins_out)
  );

  always #5 clk = ~clk;

  // Every entry starts with a fill value made from its own index.
  // Vectors end at the first entry the file left holding that value.
  task automatic load_vectors();
    for (int i = 0; i < MAX_VECS; i++) begin
      vecs[i] = ~48'(i);
    end
    $readmemh("test/idli_ex_vectors.txt", vecs);
    num_vecs = 0;
    while (num_vecs < MAX_VECS && vecs[num_vecs] !== ~48'(num_vecs)) begin
      num_vecs++;
    end
    if (num_vecs == 0) begin
      errors++;
      $display("No vectors were read from test/idli_ex_vectors.txt.");
    end
    loaded = 1'b1;
  endtask

  // Past the last vector the stage is fed invalid NOPs.
  task automatic present_vector(input int k);
    if (k < num_vecs) begin
      enc     <= vecs[k][47:32];
      enc_vld <= 1'b1;
      pins_in <= vecs[k][31:28];
    end else begin
      enc     <= 16'hf000;
      enc_vld <= 1'b0;
    end
  endtask

  task automatic collect_slice(input int s);
    wb_en[s]                                     = wb.en;
    wb_dst[s]                                    = wb.dst;
    wb_data[s*`IDLI_SLICE_W +: `IDLI_SLICE_W]    = wb.slice;
  endtask

  // Compare one finished instruction with its vector.
  task automatic check_vector(input int idx);
    logic  exp_wr;
    data_t exp_res;
    logic  exp_pred;
    pins_t exp_pins;
    reg_t  exp_dst;
    exp_wr   = vecs[idx][24];
    exp_res  = vecs[idx][23:8];
    exp_pred = vecs[idx][4];
    exp_pins = vecs[idx][3:0];
    exp_dst  = vecs[idx][43:40];
    checks++;
    if (exp_wr) begin
      if (wb_en != 4'hf) begin
        errors++;
        $display("FAIL vector %0d o_ex_wb.en: got %h expected %h", idx, wb_en, 4'hf);
      end else if (wb_data != exp_res) begin
        errors++;
        $display("FAIL vector %0d o_ex_wb.slice: got %h expected %h", idx, wb_data, exp_res);
      end
      for (int s = 0; s < 4; s++) begin
        if (wb_dst[s] != exp_dst) begin
          errors++;
          $display("FAIL vector %0d o_ex_wb.dst: got %h expected %h", idx, wb_dst[s], exp_dst);
        end
      end
    end else if (wb_en != 4'h0) begin
      // Skipped instructions and ones without a register result write nothing.
      errors++;
      $display("FAIL vector %0d o_ex_wb.en: got %h expected %h", idx, wb_en, 4'h0);
    end
    if (pred != exp_pred) begin
      errors++;
      $display("FAIL vector %0d o_ex_pred: got %h expected %h", idx, pred, exp_pred);
    end
    if (pins_out != exp_pins) begin
      errors++;
      $display("FAIL vector %0d o_ex_io_pins: got %h expected %h", idx, pins_out, exp_pins);
    end
  endtask

  // One slot of four cycles, starting just after the edge that begins ctr 0.
  // Outputs are read at falling edges, where they are settled.
  task automatic run_slot(input int k);
    for (int s = 0; s < 4; s++) begin
      if (s == 3) begin
        @(posedge clk);
        present_vector(k);
      end
      @(negedge clk);
      if (s == 0 && k >= 2) begin
        check_vector(k - 2);
      end
      // The slot marker is high only in the last cycle of the slot.
      checks++;
      if (slot !== (s == 3)) begin
        errors++;
        $display("FAIL slot %0d o_ex_slot: got %h expected %h", k, slot, s == 3);
      end
      collect_slice(s);
    end
  endtask

  initial begin : main_seq
    clk     = 1'b0;
    rst_n   = 1'b0;
    enc     = 16'hf000;
    enc_vld = 1'b0;
    pins_in = '0;
    errors  = 0;
    checks  = 0;
    wb_data = '0;
    wb_en   = '0;
    load_vectors();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // Wait for the last cycle of a slot, so that the next cycle is ctr 0.
    @(negedge clk);
    while (!slot) begin
      @(negedge clk);
    end
    // Two extra slots drain the final instruction.
    for (int k = 0; k < num_vecs + 2; k++) begin
      run_slot(k);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Each vector needs one slot of four cycles; reset and alignment fit in the margin.
  initial begin : watchdog
    wait (loaded);
    repeat (num_vecs * 4 + 100) @(posedge clk);
    $display("The watchdog expired before all vectors were checked.");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/idli_ex_vectors.txt ====
// encoding _ input pins _ write flag _ result _ P after _ output pins after, all hex
// Encoding is op dst lhs rhs, one hex digit each; LDI and COND use the low byte.
51ff_0_1_00ff_0_0
5201_0_1_0001_0_0
0312_0_1_0100_0_0
1402_0_1_ffff_0_0
0542_0_1_0000_0_0
0644_0_1_fffe_0_0
2861_0_1_00fe_0_0
4a41_0_1_ff00_0_0
1b31_0_1_0001_0_0
5055_0_1_0055_0_0
3c00_0_1_0000_0_0
6050_0_0_0000_1_0
7050_0_0_0000_0_0
8042_0_0_0000_1_0
9042_0_0_0000_0_0
a024_0_0_0000_1_0
b024_0_0_0000_0_0
b042_0_0_0000_1_0
c005_0_0_0000_1_0
5d11_0_1_0011_1_0
5522_0_0_0000_1_0
3e5d_0_1_0011_1_0
7022_0_0_0000_0_0
c006_0_0_0000_0_0
0ddd_0_1_0022_0_0
6022_0_0_0000_0_0
0fd2_0_1_0023_0_0
e022_0_0_0000_0_4
e021_0_0_0000_0_6
e062_0_0_0000_0_2
dd03_8_1_0001_0_2
dc00_6_1_0000_0_2
0cdd_0_1_0002_0_2

// ==== vlog.f ====
+incdir+include
logic/idli_pkg.sv
logic/idli_decode.sv
logic/idli_ex_ctl.sv
logic/idli_rf.sv
logic/idli_alu.sv
logic/idli_pins.sv
logic/idli_ex.sv
test/idli_ex_tb.sv
